// ==== files.f ====
+incdir+.
io_pkg.sv
io_cfg_if.sv
io_regs.sv
io_gpio.sv
io_timer.sv
io_top.sv
tb_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_io -f files.f -o tb_io_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_io_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "SIMULATION FAILED" "$log"; then
    echo "Result: failing run, see $log"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
echo "Result: passing run"
exit 0

// ==== tb_io.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "io_defs.svh"

module tb_io import io_pkg::*; ();

    localparam int clk_period     = 40;
    localparam int pwm_period_max = 256 * 2;        // PWM test uses scale 0 or 1
    localparam int ctc_half_max   = 10 * 4;         // (N+1)*(S+1) with N <= 9 and S <= 3
    localparam int watchdog_cycles =
        2 * (10 + 400 + 6 * ctc_half_max + 2 * (3 * pwm_period_max + 40) + 40);
    localparam addr_t unmapped_addr = 8'h0f;        // Hole in the register map

    logic  clk = 1'b0;
    logic  arst_n;
    data_t din;
    addr_t address;
    logic  w_en;
    logic  r_en;
    data_t dout;
    data_t pins_in;
    data_t pins_out;
    data_t pins_oe;

    data_t       exp_dir  = '0;                     // Model of the writable registers
    data_t       exp_port = '0;
    data_t       exp_ctrl = '0;
    logic [31:0] rng_state = 32'h1f25_7222;
    int          cycle_cnt = 0;

    io_top u_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    //**************************************************************************
    // Error reporting and helpers

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0d ns: %s", $time, msg);
        stop_failed();
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0d ns: %s", $time, why);
        stop_failed();
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic data_t ctrl_word(input timer_mode_t m, input logic sel6, input logic sel7);
        data_t c;
        c = '0;
        c[`IO_CTRL_MODE_MSB:`IO_CTRL_MODE_LSB] = m;
        c[`IO_CTRL_PIN6_SEL] = sel6;
        c[`IO_CTRL_PIN7_SEL] = sel7;
        return c;
    endfunction

    //**************************************************************************
    // Bus tasks driving inputs on the falling edge

    task automatic bus_write(input addr_t a, input data_t d);
        @(negedge clk);
        address = a;
        din     = d;
        w_en    = 1'b1;
        @(negedge clk);
        w_en = 1'b0;
        case (a)
            `IO_ADDR_DIR:  exp_dir  = d;
            `IO_ADDR_PORT: exp_port = d;
            `IO_ADDR_CTRL: exp_ctrl = d;
            default: ;
        endcase
    endtask

    task automatic bus_read(input addr_t a, output data_t d);
        @(negedge clk);
        address = a;
        r_en    = 1'b1;
        @(negedge clk);
        r_en = 1'b0;
        d    = dout;                                // Registered at the edge in between
    endtask

    task automatic expect_read(input addr_t a, input data_t exp, input string what);
        data_t got;
        bus_read(a, got);
        assert (got == exp) else
            report_mismatch($sformatf("%s read %h expected %h", what, got, exp));
    endtask

    task automatic wait_edge(input int idx, input int limit, output int at_cycle);
        logic prev;
        int   waited;
        prev   = pins_out[idx];
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > limit)
                abort_run($sformatf("no edge on pins_out[%0d] within %0d cycles", idx, limit));
        end while (pins_out[idx] == prev);
        at_cycle = cycle_cnt;
    endtask

    //**************************************************************************
    // GPIO drive checks

    a_oe_dir: assert property (@(posedge clk) disable iff (!arst_n) pins_oe == exp_dir)
        else report_mismatch("pins_oe differs from DIR");

    // Upper pins only follow PORT while the timer does not own them
    a_out_port: assert property (@(posedge clk) disable iff (!arst_n)
        pins_out[5:0] == exp_port[5:0] &&
        (exp_ctrl[`IO_CTRL_PIN6_SEL] || exp_ctrl[`IO_CTRL_PIN7_SEL] || pins_out == exp_port))
        else report_mismatch("pins_out differs from PORT");

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        abort_run($sformatf("watchdog expired after %0d cycles, test hung", watchdog_cycles));
    end

    //**************************************************************************
    // Stimulus

    initial begin : stimulus
        addr_t rw_addr [6];
        data_t val;
        data_t c0;
        data_t c1;
        int    n;
        int    s;
        int    t0;
        int    t1;
        int    high6;
        int    high7;

        rw_addr = '{`IO_ADDR_DIR, `IO_ADDR_PORT, `IO_ADDR_SCALE_LO,
                    `IO_ADDR_SCALE_HI, `IO_ADDR_CMPR0, `IO_ADDR_CMPR1};
        arst_n  = 1'b0;
        din     = '0;
        address = '0;
        w_en    = 1'b0;
        r_en    = 1'b0;
        pins_in = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Register readback
        // DIR and PORT writes also exercise the drive checks
        repeat (4) begin
            foreach (rw_addr[i]) begin
                val = data_t'(next_rand());
                bus_write(rw_addr[i], val);
                expect_read(rw_addr[i], val, $sformatf("register %0d", rw_addr[i]));
                expect_read(unmapped_addr, val, "unmapped address"); // Keeps the last data
            end
        end
        bus_write(`IO_ADDR_PINS, data_t'(next_rand()));
        expect_read(`IO_ADDR_PINS, '0, "PINS after write");
        bus_write(`IO_ADDR_COUNT, data_t'(next_rand()));
        expect_read(`IO_ADDR_COUNT, '0, "COUNT after write");

        repeat (8) begin
            @(negedge clk);
            pins_in = data_t'(next_rand());
            repeat (4) @(negedge clk);              // Two sync flops plus margin
            expect_read(`IO_ADDR_PINS, pins_in, "PINS");
        end

        // CTC on pin 6
        s = int'(next_rand() % 4);
        n = 2 + int'(next_rand() % 8);
        bus_write(`IO_ADDR_SCALE_HI, '0);
        bus_write(`IO_ADDR_SCALE_LO, data_t'(s));
        bus_write(`IO_ADDR_CMPR0, data_t'(n));
        bus_write(`IO_ADDR_CTRL, ctrl_word(mode_ctc, 1'b1, 1'b0));
        wait_edge(6, 4 * ctc_half_max, t0);
        repeat (3) begin
            wait_edge(6, 4 * ctc_half_max, t1);
            assert (t1 - t0 == (n + 1) * (s + 1)) else
                report_mismatch($sformatf("CTC half period %0d expected %0d",
                                          t1 - t0, (n + 1) * (s + 1)));
            t0 = t1;
        end

        // PWM on pins 6 and 7 with pin 7 held high in the second round
        bus_write(`IO_ADDR_CTRL, ctrl_word(mode_idle, 1'b1, 1'b1));
        for (int r = 0; r < 2; r++) begin
            s  = int'(next_rand() % 2);
            c0 = data_t'(next_rand());
            c1 = (r == 0) ? data_t'(next_rand()) : 8'hff;
            bus_write(`IO_ADDR_SCALE_LO, data_t'(s));
            bus_write(`IO_ADDR_CMPR0, c0);
            bus_write(`IO_ADDR_CMPR1, c1);
            bus_write(`IO_ADDR_CTRL, ctrl_word(mode_pwm, 1'b1, 1'b1));
            repeat (256 * (s + 1) + 2 * (s + 1) + 4) @(negedge clk);  // Reach steady periods
            repeat (2) begin
                high6 = 0;
                high7 = 0;
                repeat (256 * (s + 1)) begin
                    @(negedge clk);
                    if (pins_out[6])
                        high6++;
                    if (pins_out[7])
                        high7++;
                end
                assert (high6 == (int'(c0) + 1) * (s + 1)) else
                    report_mismatch($sformatf("PWM pin 6 high %0d cycles, cmpr0 %0d scale %0d",
                                              high6, c0, s));
                assert (high7 == (int'(c1) + 1) * (s + 1)) else
                    report_mismatch($sformatf("PWM pin 7 high %0d cycles, cmpr1 %0d scale %0d",
                                              high7, c1, s));
            end
        end

        // Back to idle where one tick clears everything
        bus_write(`IO_ADDR_CTRL, ctrl_word(mode_idle, 1'b1, 1'b1));
        repeat (s + 4) @(negedge clk);
        expect_read(`IO_ADDR_COUNT, '0, "COUNT in idle");
        assert (pins_out[7:6] == 2'b00) else
            report_mismatch($sformatf("timer pins %b in idle", pins_out[7:6]));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== io_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module io_top import io_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire data_t din,
    input  wire addr_t address,
    input  wire        w_en,
    input  wire        r_en,
    output data_t      dout,
    input  wire data_t pins_in,                     // From the pad cells
    output data_t      pins_out,
    output data_t      pins_oe
);

    io_cfg_if cfg_bus ();

    // Bus decode and configuration
    io_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .din     (din),
        .address (address),
        .w_en    (w_en),
        .r_en    (r_en),
        .dout    (dout),
        .cfg     (cfg_bus.regs)
    );

    // Pin synchronizer and output drive
    io_gpio u_gpio (
        .clk      (clk),
        .arst_n   (arst_n),
        .pins_in  (pins_in),
        .pins_out (pins_out),
        .pins_oe  (pins_oe),
        .cfg      (cfg_bus.gpio)
    );

    // Counter/timer
    io_timer u_timer (
        .clk    (clk),
        .arst_n (arst_n),
        .cfg    (cfg_bus.timer)
    );

endmodule

`default_nettype wire

// ==== io_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

module io_timer import io_pkg::*; (
    input  wire     clk,
    input  wire     arst_n,
    io_cfg_if.timer cfg
);

    prescale_t prescale_q;
    logic      tick;                                // One cycle per prescaler period

    data_t     count_q;
    logic      out0_q;
    logic      out1_q;

    logic      match0;
    logic      match1;

    //**************************************************************************
    // Prescaler

    // Compare with >= so a lowered scale factor takes effect right away
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale_q <= '0;
            tick       <= 1'b0;
        end else if (prescale_q >= cfg.scale_factor) begin
            prescale_q <= '0;
            tick       <= 1'b1;
        end else begin
            prescale_q <= prescale_q + 16'd1;
            tick       <= 1'b0;
        end
    end

    //**************************************************************************
    // Counter and outputs

    assign match0 = (count_q == cfg.cmpr0);
    assign match1 = (count_q == cfg.cmpr1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
            out0_q  <= 1'b0;
            out1_q  <= 1'b0;
        end else if (tick) begin
            case (cfg.mode)
                mode_idle: begin
                    count_q <= '0;
                    out0_q  <= 1'b0;
                    out1_q  <= 1'b0;
                end
                mode_ctc: begin
                    if (match0) begin
                        count_q <= '0;
                        out0_q  <= ~out0_q;         // Half period ends here
                    end else begin
                        count_q <= count_q + 8'd1;
                    end
                end
                mode_pwm: begin
                    // Both outputs rise as the counter wraps to zero
                    if (count_q == 8'hff) begin
                        out0_q <= 1'b1;
                        out1_q <= 1'b1;
                    end else begin
                        if (match0)
                            out0_q <= 1'b0;
                        if (match1)
                            out1_q <= 1'b0;
                    end
                    count_q <= count_q + 8'd1;      // Free running with a wrap at 255
                end
                default: ;                          // Hold freezes counter and outputs
            endcase
        end
    end

    assign cfg.count = count_q;
    assign cfg.out0  = out0_q;
    assign cfg.out1  = out1_q;

    //**************************************************************************
    // Checks

    a_idle_clears: assert property (
        @(posedge clk) disable iff (!arst_n)
        (tick && cfg.mode == mode_idle) |=> (count_q == '0 && !out0_q && !out1_q)
    ) else $error("idle tick did not clear the counter");

    a_tick_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        (tick && cfg.scale_factor != '0) |=> !tick
    ) else $error("prescaler tick held for two cycles");

endmodule

`default_nettype wire

// ==== io_gpio.sv ====
`default_nettype none
`timescale 1ns/100ps

module io_gpio import io_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire data_t pins_in,
    output data_t      pins_out,
    output data_t      pins_oe,
    io_cfg_if.gpio     cfg
);

    data_t sync_meta;                               // First stage may go metastable
    data_t sync_q;

    //**************************************************************************
    // Pad input synchronizer

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= pins_in;
            sync_q    <= sync_meta;
        end
    end

    assign cfg.pins = sync_q;

    //**************************************************************************
    // Output drive

    // Direction register straight to the pad enables
    assign pins_oe = cfg.dir;

    logic pin6_val;
    logic pin7_val;

    // Timer outputs override the port value on the upper pins
    assign pin6_val = cfg.pin6_sel ? cfg.out0 : cfg.port[6];
    assign pin7_val = cfg.pin7_sel ? cfg.out1 : cfg.port[7];

    assign pins_out = {pin7_val, pin6_val, cfg.port[5:0]};

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "io_defs.svh"

module io_regs import io_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire data_t din,
    input  wire addr_t address,
    input  wire        w_en,
    input  wire        r_en,
    output data_t      dout,
    io_cfg_if.regs     cfg
);

    data_t dir_q;
    data_t port_q;
    data_t scale_lo_q;
    data_t scale_hi_q;
    data_t ctrl_q;
    data_t cmpr0_q;
    data_t cmpr1_q;

    data_t rd_data;
    logic  rd_hit;                                  // Address is mapped for reads

    //**************************************************************************
    // Write decode

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dir_q      <= '0;
            port_q     <= '0;
            scale_lo_q <= '0;
            scale_hi_q <= '0;
            ctrl_q     <= '0;
            cmpr0_q    <= '0;
            cmpr1_q    <= '0;
        end else if (w_en) begin
            case (address)
                `IO_ADDR_DIR:      dir_q      <= din;
                `IO_ADDR_PORT:     port_q     <= din;
                `IO_ADDR_SCALE_LO: scale_lo_q <= din;
                `IO_ADDR_SCALE_HI: scale_hi_q <= din;
                `IO_ADDR_CTRL:     ctrl_q     <= din;
                `IO_ADDR_CMPR0:    cmpr0_q    <= din;
                `IO_ADDR_CMPR1:    cmpr1_q    <= din;
                default: ;                          // PINS, COUNT and holes ignore writes
            endcase
        end
    end

    // Configuration out to the GPIO and timer blocks
    assign cfg.dir          = dir_q;
    assign cfg.port         = port_q;
    assign cfg.scale_factor = {scale_hi_q, scale_lo_q};
    assign cfg.mode         = timer_mode_t'(ctrl_q[`IO_CTRL_MODE_MSB:`IO_CTRL_MODE_LSB]);
    assign cfg.pin6_sel     = ctrl_q[`IO_CTRL_PIN6_SEL];
    assign cfg.pin7_sel     = ctrl_q[`IO_CTRL_PIN7_SEL];
    assign cfg.cmpr0        = cmpr0_q;
    assign cfg.cmpr1        = cmpr1_q;

    //**************************************************************************
    // Read mux

    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (address)
            `IO_ADDR_DIR:      rd_data = dir_q;
            `IO_ADDR_PORT:     rd_data = port_q;
            `IO_ADDR_PINS:     rd_data = cfg.pins;
            `IO_ADDR_SCALE_LO: rd_data = scale_lo_q;
            `IO_ADDR_SCALE_HI: rd_data = scale_hi_q;
            `IO_ADDR_CTRL:     rd_data = ctrl_q;
            `IO_ADDR_CMPR0:    rd_data = cmpr0_q;
            `IO_ADDR_CMPR1:    rd_data = cmpr1_q;
            `IO_ADDR_COUNT:    rd_data = cfg.count;
            default:           rd_hit  = 1'b0;
        endcase
    end

    // Unmapped reads keep the last value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else if (r_en && rd_hit) begin
            dout <= rd_data;
        end
    end

    a_strobes_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown({w_en, r_en})
    ) else $error("bus strobe unknown out of reset");

endmodule

`default_nettype wire

// ==== io_cfg_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface io_cfg_if import io_pkg::*; ();

    // Configuration from the register block
    data_t       dir;
    data_t       port;
    prescale_t   scale_factor;
    timer_mode_t mode;
    logic        pin6_sel;
    logic        pin7_sel;
    data_t       cmpr0;
    data_t       cmpr1;

    // Status back from GPIO and timer
    data_t       pins;
    data_t       count;
    logic        out0;
    logic        out1;

    modport regs (
        output dir, port, scale_factor, mode, pin6_sel, pin7_sel, cmpr0, cmpr1,
        input  pins, count
    );

    modport gpio (
        input  dir, port, pin6_sel, pin7_sel, out0, out1,
        output pins
    );

    modport timer (
        input  scale_factor, mode, cmpr0, cmpr1,
        output count, out0, out1
    );

endinterface

`default_nettype wire

// ==== io_pkg.sv ====
`default_nettype none

package io_pkg;

    // Bus data and register contents
    typedef logic [7:0] data_t;

    // Register address on the processor bus
    typedef logic [7:0] addr_t;

    // Prescaler count and scale factor
    typedef logic [15:0] prescale_t;

    // Counter/timer operating mode where code 11 freezes everything
    typedef enum logic [1:0] {
        mode_idle = 2'b00,
        mode_ctc  = 2'b01,
        mode_pwm  = 2'b10,
        mode_hold = 2'b11
    } timer_mode_t;

endpackage

`default_nettype wire

// ==== io_defs.svh ====
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

//**************************************************************************
// Register map

`define IO_ADDR_DIR       8'h00 // Pin direction where 1 is output
`define IO_ADDR_PORT      8'h01 // Output value
`define IO_ADDR_PINS      8'h02 // Read only synchronized pad inputs
`define IO_ADDR_SCALE_LO  8'h03
`define IO_ADDR_SCALE_HI  8'h04
`define IO_ADDR_CTRL      8'h05
`define IO_ADDR_CMPR0     8'h06
`define IO_ADDR_CMPR1     8'h07
`define IO_ADDR_COUNT     8'h08 // Read only counter value

//**************************************************************************
// Control register fields

// Timer mode lives in the two low bits
`define IO_CTRL_MODE_LSB  0
`define IO_CTRL_MODE_MSB  1

// Timer outputs take over the upper two pins
`define IO_CTRL_PIN6_SEL  2
`define IO_CTRL_PIN7_SEL  3

`endif
